// ==== rtl/cache_cfg_pkg.sv ====
`default_nettype none

package cache_cfg_pkg;

    // ------------------------------------------------------------------------
    // address split
    // ------------------------------------------------------------------------

    // a lookup address is {tag, set}, no offset bits since a line is one word
    localparam int set_bits = 4;
    localparam int tag_bits = 8;

    // ------------------------------------------------------------------------
    // line store
    // ------------------------------------------------------------------------

    localparam int data_bits = 32;                 // one 32-bit word per line
    localparam int num_sets  = 1 << set_bits;      // direct mapped, one line per set

    // ------------------------------------------------------------------------
    // victim buffer
    // ------------------------------------------------------------------------

    // entries ride through these slots and leave as writebacks from the last one
    localparam int victim_slots = 4;

endpackage

`default_nettype wire

// ==== rtl/cache_types_pkg.sv ====
`default_nettype none

package cache_types_pkg;

    typedef logic [cache_cfg_pkg::set_bits-1:0]  set_t;
    typedef logic [cache_cfg_pkg::tag_bits-1:0]  tag_t;
    typedef logic [cache_cfg_pkg::data_bits-1:0] data_t;

    // index of one victim buffer slot
    typedef logic [$clog2(cache_cfg_pkg::victim_slots)-1:0] slot_t;

    typedef struct packed {
        tag_t tag;
        set_t set;
    } addr_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cache_line_t;

    // the set travels with the line because the slot no longer implies it
    typedef struct packed {
        logic        busy;      // slot is occupied
        set_t        set;
        cache_line_t line;
    } victim_entry_t;

    typedef enum logic {
        src_l1     = 1'b0,
        src_victim = 1'b1
    } hit_source_t;

endpackage

`default_nettype wire

// ==== rtl/match_cam.sv ====
`timescale 1ns/1ps
`default_nettype none

// compares one key against the value held in every victim slot
// the caller masks the result with the busy bits
module match_cam #(
    parameter type key_t = cache_types_pkg::tag_t
) (
    input  key_t                                   key,
    input  key_t [cache_cfg_pkg::victim_slots-1:0] slot_tags,
    output logic [cache_cfg_pkg::victim_slots-1:0] hits
);

    always_comb begin
        for (int i = 0; i < cache_cfg_pkg::victim_slots; i++) begin
            hits[i] = (slot_tags[i] == key);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/victim_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module victim_buffer (
    input  logic                           clock,
    input  logic                           reset,

    input  logic                           push_valid,
    input  cache_types_pkg::victim_entry_t push_entry,

    input  logic                           search_valid,
    input  cache_types_pkg::addr_t         search_addr,
    output logic                           found,
    output cache_types_pkg::cache_line_t   found_line,

    output logic                           writeback_valid,
    output cache_types_pkg::victim_entry_t writeback_entry
);

    localparam int last_slot = cache_cfg_pkg::victim_slots - 1;

    cache_types_pkg::victim_entry_t [cache_cfg_pkg::victim_slots-1:0] slots_q;
    cache_types_pkg::victim_entry_t [cache_cfg_pkg::victim_slots-1:0] slots_next;

    cache_types_pkg::tag_t [cache_cfg_pkg::victim_slots-1:0] slot_tags;
    cache_types_pkg::set_t [cache_cfg_pkg::victim_slots-1:0] slot_sets;

    logic [cache_cfg_pkg::victim_slots-1:0] tag_hits;
    logic [cache_cfg_pkg::victim_slots-1:0] set_hits;
    logic [cache_cfg_pkg::victim_slots-1:0] slot_match;

    cache_types_pkg::slot_t found_slot;
    logic                   writeback_next;

    always_comb begin
        for (int i = 0; i < cache_cfg_pkg::victim_slots; i++) begin
            slot_tags[i] = slots_q[i].line.tag;
            slot_sets[i] = slots_q[i].set;
        end
    end

    match_cam #(.key_t(cache_types_pkg::tag_t)) tag_cam_i (
        .key       (search_addr.tag),
        .slot_tags (slot_tags),
        .hits      (tag_hits)
    );

    match_cam #(.key_t(cache_types_pkg::set_t)) set_cam_i (
        .key       (search_addr.set),
        .slot_tags (slot_sets),
        .hits      (set_hits)
    );

    always_comb begin
        for (int i = 0; i < cache_cfg_pkg::victim_slots; i++) begin
            slot_match[i] = slots_q[i].busy & tag_hits[i] & set_hits[i];
        end
    end

    // walk down so that the lowest matching slot is the one left standing
    always_comb begin
        found_slot = '0;
        for (int i = last_slot; i >= 0; i--) begin
            if (slot_match[i]) begin
                found_slot = cache_types_pkg::slot_t'(i);
            end
        end
    end

    assign found      = search_valid & (|slot_match);
    assign found_line = slots_q[found_slot].line;

    // ------------------------------------------------------------------------
    // removal, shift and insert
    // ------------------------------------------------------------------------

    always_comb begin
        cache_types_pkg::victim_entry_t [cache_cfg_pkg::victim_slots-1:0] kept;

        kept = slots_q;
        if (found) begin
            kept[found_slot] = '0;   // the line goes back to L1, not to memory
        end

        // a found entry in the last slot must not also be written back
        writeback_next = kept[last_slot].busy;

        for (int i = last_slot; i > 0; i--) begin
            slots_next[i] = kept[i-1];
        end
        slots_next[0] = push_valid ? push_entry : '0;
        slots_next[0].busy = push_valid;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            slots_q         <= '0;
            writeback_valid <= 1'b0;
            writeback_entry <= '0;
        end else begin
            slots_q         <= slots_next;
            writeback_valid <= writeback_next;
            writeback_entry <= slots_q[last_slot];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic                         clock,
    input  logic                         reset,

    input  cache_types_pkg::set_t        read_set,
    output cache_types_pkg::cache_line_t read_line,

    input  logic                         write_valid,
    input  cache_types_pkg::set_t        write_set,
    input  cache_types_pkg::cache_line_t write_line
);

    // valid bits sit apart from the payload so only they need clearing
    logic [cache_cfg_pkg::num_sets-1:0] valid_q;

    cache_types_pkg::tag_t  tags_q [cache_cfg_pkg::num_sets];
    cache_types_pkg::data_t data_q [cache_cfg_pkg::num_sets];

    // combinational read, the top decides hit or swap in the same cycle
    always_comb begin
        read_line.valid = valid_q[read_set];
        read_line.tag   = tags_q[read_set];
        read_line.data  = data_q[read_set];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (write_valid) begin
            valid_q[write_set] <= write_line.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (write_valid) begin
            tags_q[write_set] <= write_line.tag;
            data_q[write_set] <= write_line.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/victim_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module victim_cache_top (
    input  logic                           clock,
    input  logic                           reset,

    input  logic                           lookup_valid,
    input  cache_types_pkg::addr_t         lookup_addr,

    input  logic                           fill_valid,
    input  cache_types_pkg::addr_t         fill_addr,
    input  cache_types_pkg::data_t         fill_data,

    output logic                           hit_valid,
    output cache_types_pkg::data_t         hit_data,
    output cache_types_pkg::hit_source_t   hit_source,
    output logic                           miss_valid,

    output logic                           writeback_valid,
    output cache_types_pkg::victim_entry_t writeback_entry
);

    logic                           lookup_take;   // lookup that is not shadowed by a fill
    cache_types_pkg::set_t          active_set;
    cache_types_pkg::cache_line_t   l1_line;
    logic                           l1_hit;

    logic                           search_valid;
    logic                           found;
    cache_types_pkg::cache_line_t   found_line;

    logic                           write_valid;
    cache_types_pkg::cache_line_t   write_line;
    logic                           push_valid;
    cache_types_pkg::victim_entry_t push_entry;

    // ------------------------------------------------------------------------
    // request decode
    // ------------------------------------------------------------------------

    assign lookup_take = lookup_valid & ~fill_valid;
    assign active_set  = fill_valid ? fill_addr.set : lookup_addr.set;

    assign l1_hit = lookup_take & l1_line.valid & (l1_line.tag == lookup_addr.tag);

    // the victim buffer is only searched when L1 missed, so a stale copy is left alone
    assign search_valid = lookup_take & ~l1_hit;

    line_store line_store_i (
        .clock       (clock),
        .reset       (reset),
        .read_set    (active_set),
        .read_line   (l1_line),
        .write_valid (write_valid),
        .write_set   (active_set),
        .write_line  (write_line)
    );

    // ------------------------------------------------------------------------
    // fill and swap
    // ------------------------------------------------------------------------

    always_comb begin
        write_valid     = fill_valid | found;
        write_line      = '0;
        write_line.valid = 1'b1;
        if (fill_valid) begin
            write_line.tag  = fill_addr.tag;
            write_line.data = fill_data;
        end else begin
            write_line.tag  = lookup_addr.tag;
            write_line.data = found_line.data;
        end

        // whatever was in L1 is displaced by either write
        push_valid      = write_valid & l1_line.valid;
        push_entry.busy = 1'b1;
        push_entry.set  = active_set;
        push_entry.line = l1_line;
    end

    victim_buffer victim_buffer_i (
        .clock           (clock),
        .reset           (reset),
        .push_valid      (push_valid),
        .push_entry      (push_entry),
        .search_valid    (search_valid),
        .search_addr     (lookup_addr),
        .found           (found),
        .found_line      (found_line),
        .writeback_valid (writeback_valid),
        .writeback_entry (writeback_entry)
    );

    // response one cycle after the sampling edge
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_valid  <= 1'b0;
            miss_valid <= 1'b0;
            hit_data   <= '0;
            hit_source <= cache_types_pkg::src_l1;
        end else begin
            hit_valid  <= l1_hit | found;
            miss_valid <= search_valid & ~found;
            hit_data   <= l1_hit ? l1_line.data : found_line.data;
            hit_source <= l1_hit ? cache_types_pkg::src_l1 : cache_types_pkg::src_victim;
        end
    end

endmodule

`default_nettype wire

// ==== verification/victim_cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// watches the DUT ports and runs a cycle-level model of the cache next to it
module victim_cache_checker (
    input  logic                           clock,
    input  logic                           reset,

    input  logic                           lookup_valid,
    input  cache_types_pkg::addr_t         lookup_addr,
    input  logic                           fill_valid,
    input  cache_types_pkg::addr_t         fill_addr,
    input  cache_types_pkg::data_t         fill_data,

    input  logic                           hit_valid,
    input  cache_types_pkg::data_t         hit_data,
    input  cache_types_pkg::hit_source_t   hit_source,
    input  logic                           miss_valid,
    input  logic                           writeback_valid,
    input  cache_types_pkg::victim_entry_t writeback_entry,

    output int                             check_count,
    output int                             error_count,
    output int                             victim_hit_count,
    output int                             writeback_count
);

    // model state plus the outputs it expects after the next edge
    typedef struct packed {
        cache_types_pkg::cache_line_t   [cache_cfg_pkg::num_sets-1:0]     l1;
        cache_types_pkg::victim_entry_t [cache_cfg_pkg::victim_slots-1:0] slots;
        logic                           hit_valid;
        cache_types_pkg::data_t         hit_data;
        cache_types_pkg::hit_source_t   hit_source;
        logic                           miss_valid;
        logic                           writeback_valid;
        cache_types_pkg::victim_entry_t writeback_entry;
    } model_t;

    model_t model;
    logic   live = 1'b0;   // set by the first reset edge, outputs are unknown before it

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic model_t step_model(
        input model_t                 s,
        input logic                   lv,
        input cache_types_pkg::addr_t la,
        input logic                   fv,
        input cache_types_pkg::addr_t fa,
        input cache_types_pkg::data_t fd
    );
        model_t                                                           n;
        cache_types_pkg::victim_entry_t [cache_cfg_pkg::victim_slots-1:0] kept;
        cache_types_pkg::cache_line_t                                     old;
        cache_types_pkg::set_t                                            set;
        logic                                                             take;
        logic                                                             l1_hit;
        logic                                                             search;
        logic                                                             any_match;
        logic                                                             found;
        logic                                                             push;
        int                                                               found_idx;
        int                                                               i;

        n         = s;
        take      = lv & ~fv;                  // a fill in the same cycle wins
        set       = fv ? fa.set : la.set;
        old       = s.l1[set];
        l1_hit    = take && old.valid && (old.tag == la.tag);
        search    = take && !l1_hit;
        any_match = 1'b0;
        found_idx = 0;
        for (i = 0; i < cache_cfg_pkg::victim_slots; i++) begin
            if (!any_match && s.slots[i].busy && s.slots[i].line.tag == la.tag
                    && s.slots[i].set == la.set) begin
                any_match = 1'b1;
                found_idx = i;
            end
        end
        found = search && any_match;

        n.hit_valid  = l1_hit | found;
        n.miss_valid = search & ~found;
        n.hit_data   = l1_hit ? old.data : s.slots[found_idx].line.data;
        n.hit_source = l1_hit ? cache_types_pkg::src_l1 : cache_types_pkg::src_victim;

        kept = s.slots;
        if (found) begin
            kept[found_idx] = '0;
        end
        n.writeback_valid = kept[cache_cfg_pkg::victim_slots-1].busy;
        n.writeback_entry = kept[cache_cfg_pkg::victim_slots-1];

        if (fv) begin
            n.l1[set].valid = 1'b1;
            n.l1[set].tag   = fa.tag;
            n.l1[set].data  = fd;
        end else if (found) begin
            n.l1[set].valid = 1'b1;
            n.l1[set].tag   = la.tag;
            n.l1[set].data  = s.slots[found_idx].line.data;
        end

        // the displaced L1 line enters slot 0 while the others move down
        push = (fv || found) && old.valid;
        for (i = cache_cfg_pkg::victim_slots - 1; i > 0; i--) begin
            n.slots[i] = kept[i-1];
        end
        n.slots[0] = '0;
        if (push) begin
            n.slots[0].busy = 1'b1;
            n.slots[0].set  = set;
            n.slots[0].line = old;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // ------------------------------------------------------------------------
    // compare, then advance with the inputs sampled at this edge
    // ------------------------------------------------------------------------

    always @(posedge clock) begin
        if (reset) begin
            model            = '0;
            live             = 1'b1;
            check_count      = 0;
            error_count      = 0;
            victim_hit_count = 0;
            writeback_count  = 0;
        end else if (live) begin
            check_value("hit_valid", 64'(hit_valid), 64'(model.hit_valid));
            check_value("miss_valid", 64'(miss_valid), 64'(model.miss_valid));
            check_value("writeback_valid", 64'(writeback_valid), 64'(model.writeback_valid));
            if (model.hit_valid) begin
                check_value("hit_data", 64'(hit_data), 64'(model.hit_data));
                check_value("hit_source", 64'(hit_source), 64'(model.hit_source));
            end
            if (model.writeback_valid) begin
                check_value("writeback_entry", 64'(writeback_entry), 64'(model.writeback_entry));
            end

            model = step_model(model, lookup_valid, lookup_addr, fill_valid, fill_addr, fill_data);
            if (model.hit_valid && model.hit_source == cache_types_pkg::src_victim) begin
                victim_hit_count++;
            end
            if (model.writeback_valid) begin
                writeback_count++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/victim_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module victim_cache_tb;

    localparam int random_cycles = 300;
    localparam int cycle_limit   = random_cycles + 400;   // directed part and drain fit well inside

    logic                           clock;
    logic                           reset;
    logic                           lookup_valid;
    cache_types_pkg::addr_t         lookup_addr;
    logic                           fill_valid;
    cache_types_pkg::addr_t         fill_addr;
    cache_types_pkg::data_t         fill_data;
    logic                           hit_valid;
    cache_types_pkg::data_t         hit_data;
    cache_types_pkg::hit_source_t   hit_source;
    logic                           miss_valid;
    logic                           writeback_valid;
    cache_types_pkg::victim_entry_t writeback_entry;

    int     check_count;
    int     error_count;
    int     victim_hit_count;
    int     writeback_count;
    int     other_errors;
    int     cycle_count = 0;
    integer seed;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    victim_cache_top victim_cache_top_i (
        .clock           (clock),
        .reset           (reset),
        .lookup_valid    (lookup_valid),
        .lookup_addr     (lookup_addr),
        .fill_valid      (fill_valid),
        .fill_addr       (fill_addr),
        .fill_data       (fill_data),
        .hit_valid       (hit_valid),
        .hit_data        (hit_data),
        .hit_source      (hit_source),
        .miss_valid      (miss_valid),
        .writeback_valid (writeback_valid),
        .writeback_entry (writeback_entry)
    );

    victim_cache_checker victim_cache_checker_i (
        .clock            (clock),
        .reset            (reset),
        .lookup_valid     (lookup_valid),
        .lookup_addr      (lookup_addr),
        .fill_valid       (fill_valid),
        .fill_addr        (fill_addr),
        .fill_data        (fill_data),
        .hit_valid        (hit_valid),
        .hit_data         (hit_data),
        .hit_source       (hit_source),
        .miss_valid       (miss_valid),
        .writeback_valid  (writeback_valid),
        .writeback_entry  (writeback_entry),
        .check_count      (check_count),
        .error_count      (error_count),
        .victim_hit_count (victim_hit_count),
        .writeback_count  (writeback_count)
    );

    function automatic cache_types_pkg::addr_t make_addr(input cache_types_pkg::tag_t tag,
                                                         input cache_types_pkg::set_t set);
        cache_types_pkg::addr_t a;

        a.tag = tag;
        a.set = set;
        return a;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus tasks, one call drives one cycle
    // ------------------------------------------------------------------------

    task automatic drive_cycle(input logic lv, input cache_types_pkg::addr_t la, input logic fv,
                               input cache_types_pkg::addr_t fa, input cache_types_pkg::data_t fd);
        @(posedge clock);
        lookup_valid <= lv;
        lookup_addr  <= la;
        fill_valid   <= fv;
        fill_addr    <= fa;
        fill_data    <= fd;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic fill_line(input cache_types_pkg::addr_t a, input cache_types_pkg::data_t d);
        drive_cycle(1'b0, '0, 1'b1, a, d);
    endtask

    task automatic lookup_line(input cache_types_pkg::addr_t a);
        drive_cycle(1'b1, a, 1'b0, '0, '0);
    endtask

    initial begin
        logic [31:0]            r;
        cache_types_pkg::addr_t a1;
        cache_types_pkg::addr_t a2;

        seed         = 32'h1b94b9f9;
        other_errors = 0;
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup_addr  = '0;
        fill_valid   = 1'b0;
        fill_addr    = '0;
        fill_data    = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        lookup_line(make_addr(8'h10, 4'h1));   // empty cache misses everywhere
        lookup_line(make_addr(8'h20, 4'h2));
        idle_cycles(2);

        fill_line(make_addr(8'h11, 4'h5), 32'hcafe_0001);
        lookup_line(make_addr(8'h11, 4'h5));
        idle_cycles(1);

        // conflict in set 5, then swap the old line back and find the new one in the buffer
        fill_line(make_addr(8'h22, 4'h5), 32'hcafe_0002);
        idle_cycles(1);
        lookup_line(make_addr(8'h11, 4'h5));
        lookup_line(make_addr(8'h11, 4'h5));
        lookup_line(make_addr(8'h22, 4'h5));
        idle_cycles(6);

        // an unclaimed victim drains out as a writeback
        fill_line(make_addr(8'h33, 4'h9), 32'hbeef_0003);
        fill_line(make_addr(8'h44, 4'h9), 32'hbeef_0004);
        idle_cycles(6);
        drive_cycle(1'b1, make_addr(8'h44, 4'h9), 1'b1, make_addr(8'h55, 4'h9), 32'hbeef_0005);
        idle_cycles(6);

        for (int k = 0; k < random_cycles; k++) begin
            r      = $random(seed);
            a1.tag = cache_types_pkg::tag_t'(r[1:0]);
            a1.set = cache_types_pkg::set_t'(r[3:2]);
            a2.tag = cache_types_pkg::tag_t'(r[5:4]);
            a2.set = cache_types_pkg::set_t'(r[7:6]);
            case (r[10:8])
                3'd0, 3'd1:       fill_line(a1, $random(seed));
                3'd2, 3'd3, 3'd4: lookup_line(a2);
                3'd5:             drive_cycle(1'b1, a2, 1'b1, a1, $random(seed));
                default:          idle_cycles(1);
            endcase
        end
        idle_cycles(8);
        @(negedge clock);

        if (victim_hit_count == 0) begin
            $display("no lookup was answered from the victim buffer");
            other_errors++;
        end
        if (writeback_count == 0) begin
            $display("no writeback came out of the victim buffer");
            other_errors++;
        end
        $display("checks: %0d  mismatches: %0d  other errors: %0d  victim hits: %0d  writebacks: %0d",
                 check_count, error_count, other_errors, victim_hit_count, writeback_count);
        if (error_count == 0 && other_errors == 0 && check_count > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/cache_cfg_pkg.sv
rtl/cache_types_pkg.sv
rtl/match_cam.sv
rtl/victim_buffer.sv
rtl/line_store.sv
rtl/victim_cache_top.sv
verification/victim_cache_checker.sv
verification/victim_cache_tb.sv

// ==== Makefile ====
TOP = victim_cache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Verification passed'

clean:
	rm -rf obj_dir
